// ==== rtl/dw_shift_params.svh ====
`ifndef DW_SHIFT_PARAMS_SVH
`define DW_SHIFT_PARAMS_SVH

// ---------------------------------------------------------------------------
// widths and counts of the depthwise output stage
// ---------------------------------------------------------------------------

// accumulator word
`define DW_WORD_WIDTH 16

// members per lane in one input beat
`define DW_MEMBERS 4

// pass-through tag
`define DW_TAG_WIDTH 4

`endif

// ==== rtl/dw_shift_pkg.sv ====
`include "dw_shift_params.svh"

package dw_shift_pkg;

  // one accumulator word
  typedef logic [`DW_WORD_WIDTH-1:0] acc_word_t;

  // all members of one lane, member 0 in the low bits
  typedef logic [`DW_MEMBERS*`DW_WORD_WIDTH-1:0] member_vec_t;

  // member index, also used for count minus one
  typedef logic [$clog2(`DW_MEMBERS)-1:0] member_idx_t;

  typedef logic [`DW_TAG_WIDTH-1:0] tag_t;

endpackage

// ==== rtl/dw_shift_lane.sv ====
`timescale 1ns/1ps
`include "dw_shift_params.svh"

module dw_shift_lane
  import dw_shift_pkg::*;
(
  input  logic        aclk,
  input  logic        arst_n,

  input  logic        s_valid,
  output logic        s_ready,
  input  member_vec_t s_data,
  input  member_idx_t s_count,
  input  tag_t        s_tag,
  input  logic        s_last,

  input  logic        lane_ready,
  output logic        lane_valid,
  output acc_word_t   lane_word,
  output member_idx_t lane_index,
  output tag_t        lane_tag,
  output logic        lane_last
);

  logic        accept;
  logic        count_en;
  logic        count_last;
  member_idx_t count;
  member_idx_t count_next;
  member_idx_t index_q;
  member_idx_t index_next;
  member_vec_t shift_q;
  member_vec_t shift_next;
  logic        valid_q;
  tag_t        tag_q;
  logic        last_q;

  // ---------------------------------------------------------------------------
  // member counter
  // ---------------------------------------------------------------------------

  assign count_last = (count == '0);                      // idle or final member
  assign count_en   = lane_ready & (count_last ? s_valid : 1'b1);
  assign count_next = count_last ? s_count : count - 1'b1;

  assign s_ready = lane_ready & count_last;
  assign accept  = s_valid & s_ready;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      count   <= '0;
      index_q <= '0;
    end else if (count_en) begin
      count   <= count_next;
      index_q <= index_next;
    end
  end

  assign index_next = count_last ? '0 : index_q + 1'b1;   // restart at member 0

  // ---------------------------------------------------------------------------
  // member shift register
  // ---------------------------------------------------------------------------

  assign shift_next = count_last ? s_data : shift_q >> `DW_WORD_WIDTH;

  always_ff @(posedge aclk) begin
    if (count_en) begin
      shift_q <= shift_next;
    end
  end

  // ---------------------------------------------------------------------------
  // beat valid, tag and last
  // ---------------------------------------------------------------------------

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      if (s_ready) begin
        valid_q <= s_valid;                               // drops after final member
      end
      if (accept) begin
        last_q <= s_last;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      tag_q <= s_tag;
    end
  end

  assign lane_valid = valid_q;
  assign lane_word  = shift_q[`DW_WORD_WIDTH-1:0];        // member in front
  assign lane_index = index_q;
  assign lane_tag   = tag_q;
  assign lane_last  = last_q & count_last;                // final member only

endmodule

// ==== rtl/dw_lane_join.sv ====
`timescale 1ns/1ps

module dw_lane_join
  import dw_shift_pkg::*;
(
  input  logic        aclk,
  input  logic        arst_n,

  input  logic        a_valid,
  input  acc_word_t   a_word,
  input  member_idx_t a_index,
  input  tag_t        a_tag,
  input  logic        a_last,
  input  logic        b_valid,
  input  acc_word_t   b_word,
  output logic        lane_ready,

  input  logic        m_ready,
  output logic        m_valid,
  output acc_word_t   m_data_0,
  output acc_word_t   m_data_1,
  output member_idx_t m_index,
  output tag_t        m_tag,
  output logic        m_last
);

  logic        in_fire;
  logic        main_free;
  logic        main_load;
  logic        spare_load;
  logic        spare_valid;
  acc_word_t   spare_word_a;
  acc_word_t   spare_word_b;
  member_idx_t spare_index;
  tag_t        spare_tag;
  logic        spare_last;

  assign lane_ready = ~spare_valid;                       // registered, no m_ready path
  assign in_fire    = a_valid & b_valid & lane_ready;
  assign main_free  = ~m_valid | m_ready;
  assign main_load  = main_free & (spare_valid | in_fire);
  assign spare_load = in_fire & ~main_free;               // main stuck, park the pair

  // ---------------------------------------------------------------------------
  // entry occupancy
  // ---------------------------------------------------------------------------

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid     <= 1'b0;
      spare_valid <= 1'b0;
    end else if (main_free) begin
      m_valid     <= spare_valid | in_fire;
      spare_valid <= 1'b0;
    end else if (in_fire) begin
      spare_valid <= 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // payload
  // ---------------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (main_load) begin
      if (spare_valid) begin                              // spare drains first
        m_data_0 <= spare_word_a;
        m_data_1 <= spare_word_b;
        m_index  <= spare_index;
        m_tag    <= spare_tag;
        m_last   <= spare_last;
      end else begin
        m_data_0 <= a_word;
        m_data_1 <= b_word;
        m_index  <= a_index;
        m_tag    <= a_tag;
        m_last   <= a_last;
      end
    end
    if (spare_load) begin
      spare_word_a <= a_word;
      spare_word_b <= b_word;
      spare_index  <= a_index;
      spare_tag    <= a_tag;
      spare_last   <= a_last;
    end
  end

endmodule

// ==== rtl/dw_shift_bank.sv ====
`timescale 1ns/1ps

module dw_shift_bank
  import dw_shift_pkg::*;
(
  input  logic        aclk,
  input  logic        arst_n,

  input  logic        s_valid,
  output logic        s_ready,
  input  member_vec_t s_data_0,
  input  member_vec_t s_data_1,
  input  member_idx_t s_count,
  input  tag_t        s_tag,
  input  logic        s_last,

  input  logic        m_ready,
  output logic        m_valid,
  output acc_word_t   m_data_0,
  output acc_word_t   m_data_1,
  output member_idx_t m_index,
  output tag_t        m_tag,
  output logic        m_last
);

  logic        lane_ready;
  logic        lane_0_valid;
  acc_word_t   lane_0_word;
  member_idx_t lane_0_index;
  tag_t        lane_0_tag;
  logic        lane_0_last;
  logic        lane_1_valid;
  acc_word_t   lane_1_word;

  // ---------------------------------------------------------------------------
  // lanes, kept in lockstep by shared inputs and ready
  // ---------------------------------------------------------------------------

  dw_shift_lane LANE_0 (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data_0),
    .s_count    (s_count),
    .s_tag      (s_tag),
    .s_last     (s_last),
    .lane_ready (lane_ready),
    .lane_valid (lane_0_valid),
    .lane_word  (lane_0_word),
    .lane_index (lane_0_index),
    .lane_tag   (lane_0_tag),
    .lane_last  (lane_0_last)
  );

  dw_shift_lane LANE_1 (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .s_valid    (s_valid),
    .s_ready    (),                     // mirrors lane 0
    .s_data     (s_data_1),
    .s_count    (s_count),
    .s_tag      (s_tag),
    .s_last     (s_last),
    .lane_ready (lane_ready),
    .lane_valid (lane_1_valid),
    .lane_word  (lane_1_word),
    .lane_index (),
    .lane_tag   (),
    .lane_last  ()
  );

  // ---------------------------------------------------------------------------
  // join and output slice
  // ---------------------------------------------------------------------------

  dw_lane_join JOIN (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .a_valid    (lane_0_valid),
    .a_word     (lane_0_word),
    .a_index    (lane_0_index),
    .a_tag      (lane_0_tag),
    .a_last     (lane_0_last),
    .b_valid    (lane_1_valid),
    .b_word     (lane_1_word),
    .lane_ready (lane_ready),
    .m_ready    (m_ready),
    .m_valid    (m_valid),
    .m_data_0   (m_data_0),
    .m_data_1   (m_data_1),
    .m_index    (m_index),
    .m_tag      (m_tag),
    .m_last     (m_last)
  );

endmodule

// ==== tb/dw_shift_bank_chk.sv ====
`timescale 1ns/1ps

module dw_shift_bank_chk
  import dw_shift_pkg::*;
(
  input logic        aclk,
  input logic        arst_n,
  input logic        s_valid,
  input logic        s_ready,
  input member_idx_t s_count,
  input logic        m_ready,
  input logic        m_valid,
  input acc_word_t   m_data_0,
  input acc_word_t   m_data_1,
  input member_idx_t m_index,
  input tag_t        m_tag,
  input logic        m_last
);

  member_idx_t final_idx [4];                             // one per beat in flight
  logic [1:0]  wr_ptr;
  logic [1:0]  rd_ptr;
  int          fail_count = 0;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (s_valid && s_ready) begin
        final_idx[wr_ptr] <= s_count;
        wr_ptr            <= wr_ptr + 1'b1;
      end
      if (m_valid && m_ready && m_index == final_idx[rd_ptr]) begin
        rd_ptr <= rd_ptr + 1'b1;                          // beat fully out
      end
    end
  end

  // --------------------------------------------------------------------------
  // protocol properties
  // --------------------------------------------------------------------------

  assert property (@(posedge aclk) !arst_n |-> !m_valid && s_ready)
    else begin
      $error("output valid or input ready wrong while in reset");
      fail_count++;
    end

  assert property (@(posedge aclk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data_0) && $stable(m_data_1)
      && $stable(m_index) && $stable(m_tag) && $stable(m_last))
    else begin
      $error("output beat changed while stalled");
      fail_count++;
    end

  assert property (@(posedge aclk) disable iff (!arst_n)
    m_valid && m_last |-> m_index == final_idx[rd_ptr])
    else begin
      $error("last flag on a member that is not the final one");
      fail_count++;
    end

endmodule

// ==== tb/dw_shift_bank_tb.sv ====
`timescale 1ns/1ps
`include "dw_shift_params.svh"

module dw_shift_bank_tb
  import dw_shift_pkg::*;
();

  localparam int TIMEOUT = 100;                           // cycles per wait

  typedef struct packed {
    acc_word_t   data_0;
    acc_word_t   data_1;
    member_idx_t index;
    tag_t        tag;
    logic        last;
  } expect_t;

  logic        aclk;
  logic        arst_n;
  logic        s_valid;
  logic        s_ready;
  member_vec_t s_data_0;
  member_vec_t s_data_1;
  member_idx_t s_count;
  tag_t        s_tag;
  logic        s_last;
  logic        m_ready;
  logic        m_valid;
  acc_word_t   m_data_0;
  acc_word_t   m_data_1;
  member_idx_t m_index;
  tag_t        m_tag;
  logic        m_last;

  expect_t     exp_q[$];
  int          errors;
  int          stall_left;                                // edges with s_ready held low
  int          tests_run;
  int          tests_failed;
  logic        random_ready;

  dw_shift_bank UUT (.*);

  bind dw_shift_bank dw_shift_bank_chk CHK (.*);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(negedge aclk) begin
    m_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  function automatic int total_errors();
    return errors + UUT.CHK.fail_count;
  endfunction

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic send_beat(input member_idx_t count, input logic last);
    int waited;
    waited = 0;
    @(negedge aclk);
    s_valid  = 1'b1;
    s_data_0 = member_vec_t'({$urandom, $urandom});
    s_data_1 = member_vec_t'({$urandom, $urandom});
    s_count  = count;
    s_tag    = tag_t'($urandom);
    s_last   = last;
    @(posedge aclk);
    while (!s_ready) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("input beat was never accepted");
      @(posedge aclk);
    end
  endtask

  task automatic idle_inputs();
    @(negedge aclk);
    s_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || m_valid) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("expected outputs never arrived");
      @(negedge aclk);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (total_errors() != errors_before) begin
      tests_failed++;
      $display("test %s: %0d errors", name, total_errors() - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ---------------------------------------------------------------------------
  // scoreboard
  // ---------------------------------------------------------------------------

  always @(posedge aclk) begin
    expect_t e;
    if (arst_n) begin
      if (stall_left > 0) begin
        check_field("s_ready", 32'd0, 32'(s_ready));      // beat still shifting
        stall_left--;
      end
      if (s_valid && s_ready) begin
        for (int i = 0; i <= int'(s_count); i++) begin
          e.data_0 = s_data_0[i*`DW_WORD_WIDTH +: `DW_WORD_WIDTH];
          e.data_1 = s_data_1[i*`DW_WORD_WIDTH +: `DW_WORD_WIDTH];
          e.index  = member_idx_t'(i);
          e.tag    = s_tag;
          e.last   = s_last && (i == int'(s_count));
          exp_q.push_back(e);
        end
        stall_left = int'(s_count);
      end
      if (m_valid && m_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("output beat arrived with nothing expected at %0t", $time);
          errors++;
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          check_field("m_data_0", 32'(e.data_0), 32'(m_data_0));
          check_field("m_data_1", 32'(e.data_1), 32'(m_data_1));
          check_field("m_index", 32'(e.index), 32'(m_index));
          check_field("m_tag", 32'(e.tag), 32'(m_tag));
          check_field("m_last", 32'(e.last), 32'(m_last));
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------

  initial begin
    int errors_before;
    void'($urandom(21579));
    arst_n       = 1'b0;
    s_valid      = 1'b0;
    s_data_0     = '0;
    s_data_1     = '0;
    s_count      = '0;
    s_tag        = '0;
    s_last       = 1'b0;
    m_ready      = 1'b1;
    random_ready = 1'b0;
    errors       = 0;
    stall_left   = 0;
    tests_run    = 0;
    tests_failed = 0;

    errors_before = total_errors();
    repeat (5) begin
      @(negedge aclk);
      check_field("m_valid", 32'd0, 32'(m_valid));
      check_field("s_ready", 32'd1, 32'(s_ready));
    end
    arst_n = 1'b1;
    wait_drain();
    repeat (3) begin
      @(negedge aclk);
      check_field("m_valid", 32'd0, 32'(m_valid));
      check_field("s_ready", 32'd1, 32'(s_ready));
    end
    finish_test("reset", errors_before);

    errors_before = total_errors();
    for (int c = 0; c < 4; c++) begin
      for (int l = 0; l < 2; l++) begin
        send_beat(member_idx_t'(c), 1'(l));
      end
    end
    idle_inputs();
    wait_drain();
    finish_test("order_and_last", errors_before);

    errors_before = total_errors();
    random_ready  = 1'b1;
    repeat (40) begin
      send_beat(member_idx_t'($urandom_range(0, 3)), 1'($urandom_range(0, 1)));
      if ($urandom_range(0, 3) == 0) idle_inputs();
    end
    idle_inputs();
    wait_drain();
    finish_test("back_pressure", errors_before);

    errors_before = total_errors();
    repeat (12) send_beat(member_idx_t'(3), 1'($urandom_range(0, 1)));   // held back to back
    idle_inputs();
    wait_drain();
    finish_test("input_stall", errors_before);

    errors_before = total_errors();
    random_ready  = 1'b0;
    send_beat(member_idx_t'(3), 1'b1);
    idle_inputs();
    for (int k = 1; k <= 6; k++) begin
      @(posedge aclk);
      check_field("m_valid", (k >= 2 && k <= 5) ? 32'd1 : 32'd0, 32'(m_valid));
    end
    wait_drain();
    finish_test("latency", errors_before);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== dw_shift_bank.f ====
+incdir+rtl
rtl/dw_shift_pkg.sv
rtl/dw_shift_lane.sv
rtl/dw_lane_join.sv
rtl/dw_shift_bank.sv
tb/dw_shift_bank_chk.sv
tb/dw_shift_bank_tb.sv

// ==== Makefile ====
# Verilator flow for the depthwise shift stage

VERILATOR ?= verilator
TOP       ?= dw_shift_bank_tb
FILELIST  ?= dw_shift_bank.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
